/* flist.f */
logic/neural_pkg.sv
logic/fp_mul.sv
logic/fp_add.sv
logic/systolic_array.sv
logic/frame_receiver.sv
logic/result_sender.sv
logic/neural_core_top.sv
testbench/tb_neural_core.sv

/* logic/fp_add.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_add (
    input  wire neural_pkg::word_t a_i,
    input  wire neural_pkg::word_t b_i,
    output neural_pkg::word_t      sum_o
);

    localparam int WW = neural_pkg::WORD_W;
    localparam int EW = neural_pkg::EXP_W;
    localparam int MW = neural_pkg::MAN_W;

    neural_pkg::word_t big;
    neural_pkg::word_t lesser;
    logic [EW-1:0]     exp_big;
    logic [EW-1:0]     exp_small;
    logic [EW-1:0]     exp_diff;
    logic [MW:0]       sig_small;       // Aligned to the larger operand
    logic [MW+1:0]     sig_sum;         // One carry bit
    logic              special;

    // Order by magnitude, sign bit ignored
    assign big    = (a_i[WW-2:0] < b_i[WW-2:0]) ? b_i : a_i;
    assign lesser = (a_i[WW-2:0] < b_i[WW-2:0]) ? a_i : b_i;

    assign exp_big   = big[WW-2 -: EW];
    assign exp_small = lesser[WW-2 -: EW];
    assign exp_diff  = exp_big - exp_small;
    assign sig_small = {1'b1, lesser[MW-1:0]} >> exp_diff;  // Bits shifted out are lost
    assign sig_sum   = {1'b0, 1'b1, big[MW-1:0]} + {1'b0, sig_small};

    assign special = (&a_i[WW-2 -: EW]) || (&b_i[WW-2 -: EW]);

    always_comb begin
        if (a_i[WW-2 -: EW] == '0) begin
            sum_o = b_i;
        end else if (b_i[WW-2 -: EW] == '0) begin
            sum_o = a_i;
        end else if (special) begin
            sum_o = '0;
        end else if (big[WW-1] != lesser[WW-1]) begin
            // Unlike signs give the larger operand's sign and exponent only
            sum_o = {big[WW-1], exp_big, {MW{1'b0}}};
        end else if (sig_sum[MW+1]) begin
            sum_o = {big[WW-1], exp_big + 1'b1, sig_sum[MW:1]};  // Carry out, renormalize
        end else begin
            sum_o = {big[WW-1], exp_big, sig_sum[MW-1:0]};
        end
    end

endmodule

`default_nettype wire

/* logic/fp_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mul (
    input  wire neural_pkg::word_t a_i,
    input  wire neural_pkg::word_t b_i,
    output neural_pkg::word_t      product_o
);

    localparam int EW      = neural_pkg::EXP_W;
    localparam int MW      = neural_pkg::MAN_W;
    localparam int EXP_MAX = 254;       // Largest finite exponent

    logic [EW-1:0]   exp_a;
    logic [EW-1:0]   exp_b;
    logic [MW:0]     sig_a;
    logic [MW:0]     sig_b;
    logic [2*MW+1:0] prod;              // Full significand product
    logic            norm;
    logic [MW-1:0]   man;
    logic [EW+1:0]   exp_sum;           // Two guard bits for the biased sum
    logic [EW+1:0]   exp_res;
    logic            sign;
    logic            zero;
    logic            out_of_range;

    assign exp_a = a_i[neural_pkg::WORD_W-2 -: EW];
    assign exp_b = b_i[neural_pkg::WORD_W-2 -: EW];
    assign sig_a = {1'b1, a_i[MW-1:0]};  // Hidden one restored
    assign sig_b = {1'b1, b_i[MW-1:0]};
    assign sign  = a_i[neural_pkg::WORD_W-1] ^ b_i[neural_pkg::WORD_W-1];
    assign zero  = (exp_a == '0) || (exp_b == '0);

    assign prod = sig_a * sig_b;
    assign norm = prod[2*MW+1];         // Product in [2,4), shift once

    // Truncate, drop the leading one
    assign man = norm ? prod[2*MW -: MW] : prod[2*MW-1 -: MW];

    assign exp_sum = {2'b00, exp_a} + {2'b00, exp_b} + {{(EW+1){1'b0}}, norm};
    assign exp_res = exp_sum - (EW+2)'(neural_pkg::EXP_BIAS);

    assign out_of_range = (exp_sum < (EW+2)'(neural_pkg::EXP_BIAS))
                       || (exp_sum > (EW+2)'(neural_pkg::EXP_BIAS + EXP_MAX));

    always_comb begin
        if (zero) begin
            product_o = '0;
        end else if (out_of_range) begin
            product_o = {sign, {EW{1'b1}}, {MW{1'b0}}};  // Saturate to all-ones exponent
        end else begin
            product_o = {sign, exp_res[EW-1:0], man};
        end
    end

endmodule

`default_nettype wire

/* logic/frame_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_receiver (
    input  wire                    clk,
    input  wire                    reset,
    input  wire neural_pkg::byte_t in_byte_i,
    input  wire                    in_valid_i,
    output logic                   in_ready_o,
    input  wire                    sent_i,
    output neural_pkg::word_t      a0_o,
    output neural_pkg::word_t      a1_o,
    output neural_pkg::word_t      a2_o,
    output neural_pkg::word_t      a3_o,
    output neural_pkg::word_t      b0_o,
    output neural_pkg::word_t      b1_o,
    output neural_pkg::word_t      b2_o,
    output neural_pkg::word_t      b3_o,
    output logic                   load_o
);

    localparam int         WW       = neural_pkg::WORD_W;
    localparam logic [3:0] LAST_IDX = 4'd15;  // Sixteen payload bytes

    neural_pkg::rx_state_t state_q;
    logic [3:0]            idx_q;
    logic [8*WW-1:0]       pay_q;             // Payload bytes, first byte ends up on top
    neural_pkg::word_t     word_q [8];        // A then B, row-major
    logic                  take;
    logic                  eof_hit;

    assign in_ready_o = (state_q != neural_pkg::BUSY) && !load_o;
    assign take       = in_valid_i && in_ready_o;
    assign eof_hit    = take && (state_q == neural_pkg::WAIT_EOF)
                     && (in_byte_i == neural_pkg::EOF_BYTE);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= neural_pkg::WAIT_SOF;
            idx_q   <= '0;
            load_o  <= 1'b0;
        end else begin
            load_o <= eof_hit;
            case (state_q)
                neural_pkg::WAIT_SOF: begin
                    if (take && in_byte_i == neural_pkg::SOF_BYTE) begin
                        state_q <= neural_pkg::PAYLOAD;
                        idx_q   <= '0;
                    end
                end
                neural_pkg::PAYLOAD: begin
                    if (take) begin
                        idx_q <= idx_q + 4'd1;
                        if (idx_q == LAST_IDX) begin
                            state_q <= neural_pkg::WAIT_EOF;
                        end
                    end
                end
                neural_pkg::WAIT_EOF: begin
                    if (load_o) begin
                        state_q <= neural_pkg::BUSY;  // Input shut until results leave
                    end
                end
                neural_pkg::BUSY: begin
                    if (sent_i) begin
                        state_q <= neural_pkg::WAIT_SOF;
                    end
                end
                default: state_q <= neural_pkg::WAIT_SOF;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take && state_q == neural_pkg::PAYLOAD) begin
            pay_q <= {pay_q[8*WW-9:0], in_byte_i};
        end
        if (eof_hit) begin
            for (int w = 0; w < 8; w++) begin
                word_q[w] <= pay_q[(7-w)*WW +: WW];
            end
        end
    end

    assign a0_o = word_q[0];
    assign a1_o = word_q[1];
    assign a2_o = word_q[2];
    assign a3_o = word_q[3];
    assign b0_o = word_q[4];
    assign b1_o = word_q[5];
    assign b2_o = word_q[6];
    assign b3_o = word_q[7];

    // No new load once the input is closed
    a_no_load_in_busy: assert property (@(posedge clk) disable iff (!reset)
        load_o |-> state_q != neural_pkg::BUSY);

endmodule

`default_nettype wire

/* logic/neural_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module neural_core_top (
    input  wire                    clk,
    input  wire                    reset,
    input  wire neural_pkg::byte_t in_byte_i,
    input  wire                    in_valid_i,
    output wire                    in_ready_o,
    output wire neural_pkg::byte_t out_byte_o,
    output wire                    out_valid_o,
    input  wire                    out_ready_i
);

    neural_pkg::word_t a0, a1, a2, a3;
    neural_pkg::word_t b0, b1, b2, b3;
    neural_pkg::word_t c0, c1, c2, c3;
    logic              load;
    logic              done;
    logic              sent;             // Output EOF accepted, reopen input

    frame_receiver u_rx (
        .clk(clk), .reset(reset),
        .in_byte_i(in_byte_i), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
        .sent_i(sent),
        .a0_o(a0), .a1_o(a1), .a2_o(a2), .a3_o(a3),
        .b0_o(b0), .b1_o(b1), .b2_o(b2), .b3_o(b3),
        .load_o(load)
    );

    systolic_array u_array (
        .clk(clk), .reset(reset),
        .a0_i(a0), .a1_i(a1), .a2_i(a2), .a3_i(a3),
        .b0_i(b0), .b1_i(b1), .b2_i(b2), .b3_i(b3),
        .load_i(load),
        .c0_o(c0), .c1_o(c1), .c2_o(c2), .c3_o(c3),
        .done_o(done)
    );

    result_sender u_tx (
        .clk(clk), .reset(reset),
        .c0_i(c0), .c1_i(c1), .c2_i(c2), .c3_i(c3),
        .done_i(done),
        .out_byte_o(out_byte_o), .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
        .sent_o(sent)
    );

endmodule

`default_nettype wire

/* logic/neural_pkg.sv */
`default_nettype none

package neural_pkg;

    // Float format: sign, exponent, mantissa
    localparam int WORD_W   = 16;
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 7;
    localparam int EXP_BIAS = 127;

    typedef logic [WORD_W-1:0] word_t;  // One float word
    typedef logic [7:0]        byte_t;  // One stream byte

    // Frame delimiters, same on both directions
    localparam byte_t SOF_BYTE = 8'hFE;
    localparam byte_t EOF_BYTE = 8'hFF;

    // Input side
    typedef enum logic [1:0] {
        WAIT_SOF,
        PAYLOAD,
        WAIT_EOF,
        BUSY                            // Job in flight, input closed
    } rx_state_t;

    // Output side
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SOF,
        TX_DATA,
        TX_EOF
    } tx_state_t;

    // Systolic array sequencing
    typedef enum logic {
        ARR_IDLE,
        ARR_RUN
    } arr_state_t;

endpackage

`default_nettype wire

/* logic/result_sender.sv */
`timescale 1ns/10ps
`default_nettype none

module result_sender (
    input  wire                    clk,
    input  wire                    reset,
    input  wire neural_pkg::word_t c0_i,
    input  wire neural_pkg::word_t c1_i,
    input  wire neural_pkg::word_t c2_i,
    input  wire neural_pkg::word_t c3_i,
    input  wire                    done_i,
    output neural_pkg::byte_t      out_byte_o,
    output logic                   out_valid_o,
    input  wire                    out_ready_i,
    output logic                   sent_o
);

    neural_pkg::tx_state_t state_q;
    logic [2:0]            idx_q;        // Word select and high/low byte
    neural_pkg::word_t     res_q [4];
    neural_pkg::word_t     cur_word;
    logic                  xfer;

    assign out_valid_o = (state_q != neural_pkg::TX_IDLE);
    assign xfer        = out_valid_o && out_ready_i;
    assign sent_o      = (state_q == neural_pkg::TX_EOF) && out_ready_i;
    assign cur_word    = res_q[idx_q[2:1]];

    always_comb begin
        case (state_q)
            neural_pkg::TX_SOF:  out_byte_o = neural_pkg::SOF_BYTE;
            neural_pkg::TX_DATA: out_byte_o = idx_q[0] ? cur_word[7:0] : cur_word[15:8];
            neural_pkg::TX_EOF:  out_byte_o = neural_pkg::EOF_BYTE;
            default:             out_byte_o = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= neural_pkg::TX_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                neural_pkg::TX_IDLE: if (done_i) state_q <= neural_pkg::TX_SOF;
                neural_pkg::TX_SOF: begin
                    if (xfer) begin
                        state_q <= neural_pkg::TX_DATA;
                        idx_q   <= '0;
                    end
                end
                neural_pkg::TX_DATA: begin
                    if (xfer) begin
                        idx_q <= idx_q + 3'd1;
                        if (idx_q == 3'd7) state_q <= neural_pkg::TX_EOF;  // Last low byte
                    end
                end
                neural_pkg::TX_EOF: if (xfer) state_q <= neural_pkg::TX_IDLE;
                default: state_q <= neural_pkg::TX_IDLE;
            endcase
        end
    end

    // Results held here so the array is free once done
    always_ff @(posedge clk) begin
        if (done_i && state_q == neural_pkg::TX_IDLE) begin
            res_q[0] <= c0_i;
            res_q[1] <= c1_i;
            res_q[2] <= c2_i;
            res_q[3] <= c3_i;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!reset)
        (out_valid_o && !out_ready_i) |=> $stable(out_byte_o));

endmodule

`default_nettype wire

/* logic/systolic_array.sv */
`timescale 1ns/10ps
`default_nettype none

module systolic_array (
    input  wire                    clk,
    input  wire                    reset,
    input  wire neural_pkg::word_t a0_i,
    input  wire neural_pkg::word_t a1_i,
    input  wire neural_pkg::word_t a2_i,
    input  wire neural_pkg::word_t a3_i,
    input  wire neural_pkg::word_t b0_i,
    input  wire neural_pkg::word_t b1_i,
    input  wire neural_pkg::word_t b2_i,
    input  wire neural_pkg::word_t b3_i,
    input  wire                    load_i,
    output neural_pkg::word_t      c0_o,
    output neural_pkg::word_t      c1_o,
    output neural_pkg::word_t      c2_o,
    output neural_pkg::word_t      c3_o,
    output logic                   done_o
);

    localparam logic [2:0] LAST_CNT = 3'd4;  // Load cycle plus four shift cycles

    neural_pkg::arr_state_t state_q;
    logic [2:0]             cnt_q;
    neural_pkg::word_t      w_q [4];     // Stationary weights, B row-major
    neural_pkg::word_t      act0_q [3];  // Column 0 of A, enters PE row 0
    neural_pkg::word_t      act1_q [3];  // Column 1 of A, one slot later
    neural_pkg::word_t      east0_q;
    neural_pkg::word_t      east1_q;
    neural_pkg::word_t      top0_q;      // Partial sums leaving the top row
    neural_pkg::word_t      top1_q;
    neural_pkg::word_t      sk0_q [3];   // Column skew buffer, col 0 finishes first
    neural_pkg::word_t      sk1_q [2];
    neural_pkg::word_t      m00;
    neural_pkg::word_t      m01;
    neural_pkg::word_t      m10;
    neural_pkg::word_t      m11;
    neural_pkg::word_t      s0;
    neural_pkg::word_t      s1;

    // Top row only multiplies, its product goes straight south
    fp_mul u_mul00 (.a_i(act0_q[0]), .b_i(w_q[0]), .product_o(m00));
    fp_mul u_mul01 (.a_i(east0_q),   .b_i(w_q[1]), .product_o(m01));
    fp_mul u_mul10 (.a_i(act1_q[0]), .b_i(w_q[2]), .product_o(m10));
    fp_mul u_mul11 (.a_i(east1_q),   .b_i(w_q[3]), .product_o(m11));

    fp_add u_add0 (.a_i(top0_q), .b_i(m10), .sum_o(s0));
    fp_add u_add1 (.a_i(top1_q), .b_i(m11), .sum_o(s1));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= neural_pkg::ARR_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                neural_pkg::ARR_IDLE: begin
                    if (load_i) begin
                        state_q <= neural_pkg::ARR_RUN;
                        cnt_q   <= 3'd1;
                    end
                end
                neural_pkg::ARR_RUN: begin
                    if (cnt_q == LAST_CNT) begin
                        state_q <= neural_pkg::ARR_IDLE;
                        done_o  <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 3'd1;
                    end
                end
                default: state_q <= neural_pkg::ARR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            w_q[0]    <= b0_i;
            w_q[1]    <= b1_i;
            w_q[2]    <= b2_i;
            w_q[3]    <= b3_i;
            act0_q[0] <= a0_i;
            act0_q[1] <= a2_i;
            act0_q[2] <= '0;
            act1_q[0] <= '0;             // Skew slot
            act1_q[1] <= a1_i;
            act1_q[2] <= a3_i;
        end else if (state_q == neural_pkg::ARR_RUN) begin
            for (int s = 0; s < 2; s++) begin
                act0_q[s] <= act0_q[s+1];
                act1_q[s] <= act1_q[s+1];
            end
            act0_q[2] <= '0;
            act1_q[2] <= '0;
            east0_q   <= act0_q[0];      // Activations move east
            east1_q   <= act1_q[0];
            top0_q    <= m00;            // Sums move south
            top1_q    <= m01;
            sk0_q[0]  <= s0;
            sk0_q[1]  <= sk0_q[0];
            sk0_q[2]  <= sk0_q[1];
            sk1_q[0]  <= s1;
            sk1_q[1]  <= sk1_q[0];
        end
    end

    // Skew buffer freezes when the run stops, so results hold until the next load
    assign c0_o = sk0_q[2];
    assign c1_o = sk1_q[1];
    assign c2_o = sk0_q[1];
    assign c3_o = sk1_q[0];

    // Receiver must stay closed for the whole run
    a_no_load_in_run: assert property (@(posedge clk) disable iff (!reset)
        load_i |-> state_q != neural_pkg::ARR_RUN);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the neural core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_neural_core -o sim_neural
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_neural)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1

/* testbench/neural_trace.txt */
// One job per line, hex: noise count, a00 a01 a10 a11, b00 b01 b10 b11,
// then expected c00 c01 c10 c11
0 3F80 4000 4040 4080  3F80 0000 0000 3F80  3F80 4000 4040 4080
3 3FC0 3FC0 4000 3F80  3F80 3FC0 3F80 3F80  4040 4070 4040 4080
1 3F80 BF80 4000 BF00  4040 3F80 3F80 3F80  4000 3F80 4080 4000
0 0040 3F80 BF80 C000  4000 0000 3FC0 8000  3FC0 0000 C0A0 0000
2 3F81 3E80 40A0 3FFF  3F81 3F80 3FA0 4000  3FAA 3FC1 40F0 410F
1 7F00 3F80 3F80 3F80  4000 3F80 3F80 4040  0000 7F00 4040 4080
4 0080 3F80 3F80 0000  0080 3F80 4000 4000  0000 4000 0080 3F80
0 BFC0 BFC0 3F80 3F00  3F80 3F80 3F80 3F80  C040 C040 3FC0 3FC0

/* testbench/tb_neural_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_neural_core;

    localparam int JOBS    = 8;
    localparam int COLS    = 13;         // Noise count, 8 operands, 4 results
    localparam int TIMEOUT = 200;        // Cycles allowed for any single wait

    logic                clk;
    logic                reset;
    neural_pkg::byte_t   in_byte;
    logic                in_valid;
    logic                in_ready;
    neural_pkg::byte_t   out_byte;
    logic                out_valid;
    logic                out_ready;

    logic [15:0] trace_mem [JOBS*COLS];
    int          errors;
    bit          timed_out;

    neural_core_top dut (
        .clk(clk), .reset(reset),
        .in_byte_i(in_byte), .in_valid_i(in_valid), .in_ready_o(in_ready),
        .out_byte_o(out_byte), .out_valid_o(out_valid), .out_ready_i(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input neural_pkg::byte_t got,
                              input neural_pkg::byte_t expected);
        if (got !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input neural_pkg::word_t got,
                              input neural_pkg::word_t expected);
        if (got !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_byte(input neural_pkg::byte_t b);
        int waited;
        if (timed_out) return;
        repeat ($urandom % 3) begin     // Random idle gap
            @(posedge clk);
            #1;
        end
        in_byte  = b;
        in_valid = 1'b1;
        waited   = 0;
        while (!in_ready && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!in_ready) begin
            $display("Timeout: the input side did not accept a byte within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end else begin
            @(posedge clk);             // Transfer edge
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic receive_byte(output neural_pkg::byte_t b);
        int waited;
        bit got;
        b      = '0;
        got    = 1'b0;
        waited = 0;
        if (timed_out) return;
        while (!got && waited < TIMEOUT) begin
            out_ready = ($urandom % 3) != 0;  // Stall about a third of the cycles
            check_flag("in_ready_o", in_ready, 1'b0);  // Input closed until output EOF
            if (out_valid && out_ready) begin
                b   = out_byte;
                got = 1'b1;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        if (!got) begin
            $display("Timeout: no output byte arrived within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_frame(input int job);
        int base;
        int noise;
        base  = job * COLS;
        noise = int'(trace_mem[base]);
        for (int n = 0; n < noise; n++) begin
            send_byte(neural_pkg::byte_t'($urandom % 254));  // Never FE
        end
        send_byte(neural_pkg::SOF_BYTE);
        for (int k = 1; k <= 8; k++) begin
            send_byte(trace_mem[base+k][15:8]);
            send_byte(trace_mem[base+k][7:0]);
        end
        send_byte(neural_pkg::EOF_BYTE);
    endtask

    task automatic receive_frame(input int job);
        neural_pkg::byte_t hi;
        neural_pkg::byte_t lo;
        int base;
        base = job * COLS;
        receive_byte(hi);
        if (timed_out) return;
        check_byte($sformatf("out_byte_o SOF, job %0d", job), hi, neural_pkg::SOF_BYTE);
        for (int k = 0; k < 4; k++) begin
            receive_byte(hi);
            receive_byte(lo);
            if (timed_out) return;
            check_word($sformatf("c%0d, job %0d", k, job), {hi, lo}, trace_mem[base+9+k]);
        end
        receive_byte(lo);
        if (timed_out) return;
        check_byte($sformatf("out_byte_o EOF, job %0d", job), lo, neural_pkg::EOF_BYTE);
        check_flag("in_ready_o after EOF", in_ready, 1'b1);  // Reopened for the next job
    endtask

    initial begin
        errors    = 0;
        timed_out = 1'b0;
        reset     = 1'b0;
        in_byte   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        void'($urandom(24));
        $readmemh("testbench/neural_trace.txt", trace_mem);

        repeat (3) @(posedge clk);
        #1 reset = 1'b1;
        @(posedge clk);
        #1;
        check_flag("in_ready_o after reset", in_ready, 1'b1);
        check_flag("out_valid_o after reset", out_valid, 1'b0);

        for (int j = 0; j < JOBS && !timed_out; j++) begin
            send_frame(j);
            receive_frame(j);
        end

        $display("Run finished: %0d errors, %0d timeouts", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
